// ==== logic/isa_pkg.sv ====
package isa_pkg;

    // data path and register file sizes
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;

    // instruction field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 26;
    localparam int RS_HI     = 25;
    localparam int RS_LO     = 21;
    localparam int RT_HI     = 20;
    localparam int RT_LO     = 16;
    localparam int RD_HI     = 15;
    localparam int RD_LO     = 11;
    localparam int FUNCT_HI  = 5;
    localparam int FUNCT_LO  = 0;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [WORD_W-1:0]     word_t;

    // the only major opcodes that get decoded
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_SLTI  = 6'd10,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14
    } opcode_e;

    // r-type function codes
    typedef enum logic [5:0] {
        F_ADD = 6'd32,
        F_SUB = 6'd34,
        F_AND = 6'd36,
        F_OR  = 6'd37,
        F_XOR = 6'd38,
        F_SLT = 6'd42
    } funct_e;

    // operations one alu lane can perform
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

endpackage

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // fetch address space
    localparam int PC_W = 8;

    typedef logic [PC_W-1:0] pc_t;

    localparam pc_t PC_RESET = '0;

    // one decoded instruction
    typedef struct packed {
        reg_addr_t src_a;
        reg_addr_t src_b;
        logic      uses_imm;
        word_t     imm;
        alu_op_e   alu_op;
        reg_addr_t dest;
        logic      writes;
    } uop_t;

    // issued pair with lane a as the older instruction
    typedef struct packed {
        uop_t lane_a;
        uop_t lane_b;
        logic valid_a;
        logic valid_b;
    } packet_t;

    // one retired register write
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } wb_lane_t;

    typedef struct packed {
        wb_lane_t wb_a;
        wb_lane_t wb_b;
    } wb_pair_t;

endpackage

// ==== logic/alu.sv ====
module alu
    import isa_pkg::*;
(
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic less;

    // signed compare for slt and slti
    assign less = ($signed(a) < $signed(b));

    always_comb
    begin
        case (op)
            ALU_ADD:
            begin
                result = a + b;
            end
            ALU_SUB:
            begin
                result = a - b;
            end
            ALU_AND:
            begin
                result = a & b;
            end
            ALU_OR:
            begin
                result = a | b;
            end
            ALU_XOR:
            begin
                result = a ^ b;
            end
            ALU_SLT:
            begin
                result = {{(WORD_W-1){1'b0}}, less};
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== logic/register_file.sv ====
module register_file
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rd_addr_a0,
    input  reg_addr_t rd_addr_a1,
    input  reg_addr_t rd_addr_b0,
    input  reg_addr_t rd_addr_b1,
    output word_t     rd_data_a0,
    output word_t     rd_data_a1,
    output word_t     rd_data_b0,
    output word_t     rd_data_b1,
    input  logic      we_a,
    input  logic      we_b,
    input  reg_addr_t wr_addr_a,
    input  reg_addr_t wr_addr_b,
    input  word_t     wr_data_a,
    input  word_t     wr_data_b
);

    word_t regs [NUM_REGS];

    // register 0 is hardwired to zero
    assign rd_data_a0 = (rd_addr_a0 == '0) ? '0 : regs[rd_addr_a0];
    assign rd_data_a1 = (rd_addr_a1 == '0) ? '0 : regs[rd_addr_a1];
    assign rd_data_b0 = (rd_addr_b0 == '0) ? '0 : regs[rd_addr_b0];
    assign rd_data_b1 = (rd_addr_b1 == '0) ? '0 : regs[rd_addr_b1];

    // two write ports whose addresses never collide
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            if (we_a)
            begin
                regs[wr_addr_a] <= wr_data_a;
            end
            if (we_b)
            begin
                regs[wr_addr_b] <= wr_data_b;
            end
        end
    end

endmodule

// ==== logic/issue_unit.sv ====
module issue_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  word_t   inst_a,
    input  word_t   inst_b,
    output pc_t     pc,
    output packet_t issue_pkt
);

    uop_t uop_a;
    uop_t uop_b;
    logic b_rtype;
    logic split;

    function automatic alu_op_e funct_to_op(input funct_e fn);
        alu_op_e op;
        case (fn)
            F_SUB:   op = ALU_SUB;
            F_AND:   op = ALU_AND;
            F_OR:    op = ALU_OR;
            F_XOR:   op = ALU_XOR;
            F_SLT:   op = ALU_SLT;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    function automatic uop_t decode(input word_t inst);
        uop_t             u;
        opcode_e          opc;
        funct_e           fn;
        logic [IMM_W-1:0] raw;
        opc = opcode_e'(inst[OPCODE_HI:OPCODE_LO]);
        fn  = funct_e'(inst[FUNCT_HI:FUNCT_LO]);
        raw = inst[IMM_W-1:0];
        u = '0;
        u.src_a    = inst[RS_HI:RS_LO];
        u.src_b    = inst[RT_HI:RT_LO];
        u.dest     = inst[RT_HI:RT_LO];
        u.uses_imm = 1'b1;
        u.writes   = 1'b1;
        // addi and slti sign extend while the logical ones zero extend
        if (opc == OP_ADDI || opc == OP_SLTI)
        begin
            u.imm = {{(WORD_W-IMM_W){raw[IMM_W-1]}}, raw};
        end
        else
        begin
            u.imm = {{(WORD_W-IMM_W){1'b0}}, raw};
        end
        case (opc)
            OP_RTYPE:
            begin
                u.uses_imm = 1'b0;
                u.dest     = inst[RD_HI:RD_LO];
                u.alu_op   = funct_to_op(fn);
                u.writes   = fn inside {F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_SLT};
            end
            OP_ADDI: u.alu_op = ALU_ADD;
            OP_SLTI: u.alu_op = ALU_SLT;
            OP_ANDI: u.alu_op = ALU_AND;
            OP_ORI:  u.alu_op = ALU_OR;
            OP_XORI: u.alu_op = ALU_XOR;
            default: u.writes = 1'b0;
        endcase
        return u;
    endfunction

    assign uop_a = decode(inst_a);
    assign uop_b = decode(inst_b);

    // rt is only a source for r-type
    assign b_rtype = (inst_b[OPCODE_HI:OPCODE_LO] == OP_RTYPE);

    // raw dependency inside the pair makes lane b wait one cycle
    assign split = uop_a.writes && (uop_a.dest != '0) &&
                   ((uop_b.src_a == uop_a.dest) ||
                    (b_rtype && (uop_b.src_b == uop_a.dest)));

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            pc        <= PC_RESET;
            issue_pkt <= '0;
        end
        else
        begin
            // on a split the second word comes back as lane a
            pc        <= split ? pc + pc_t'(1) : pc + pc_t'(2);
            issue_pkt <= '{lane_a:  uop_a,
                           lane_b:  uop_b,
                           valid_a: 1'b1,
                           valid_b: !split};
        end
    end

endmodule

// ==== logic/execute_unit.sv ====
module execute_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  packet_t  issue_pkt,
    output wb_pair_t wb
);

    word_t    rs_data_a;
    word_t    rt_data_a;
    word_t    rs_data_b;
    word_t    rt_data_b;
    word_t    opnd_a;
    word_t    opnd_b;
    word_t    result_a;
    word_t    result_b;
    logic     lane_a_wr;
    logic     we_a;
    logic     we_b;
    wb_pair_t wb_next;

    // issue_pkt is the held packet, read during the cycle after issue
    register_file u_register_file (
        .clk        (clk),
        .reset      (reset),
        .rd_addr_a0 (issue_pkt.lane_a.src_a),
        .rd_addr_a1 (issue_pkt.lane_a.src_b),
        .rd_addr_b0 (issue_pkt.lane_b.src_a),
        .rd_addr_b1 (issue_pkt.lane_b.src_b),
        .rd_data_a0 (rs_data_a),
        .rd_data_a1 (rt_data_a),
        .rd_data_b0 (rs_data_b),
        .rd_data_b1 (rt_data_b),
        .we_a       (we_a),
        .we_b       (we_b),
        .wr_addr_a  (issue_pkt.lane_a.dest),
        .wr_addr_b  (issue_pkt.lane_b.dest),
        .wr_data_a  (result_a),
        .wr_data_b  (result_b)
    );

    // second operand is the immediate for i-type
    assign opnd_a = issue_pkt.lane_a.uses_imm ? issue_pkt.lane_a.imm : rt_data_a;
    assign opnd_b = issue_pkt.lane_b.uses_imm ? issue_pkt.lane_b.imm : rt_data_b;

    alu u_alu_a (
        .op     (issue_pkt.lane_a.alu_op),
        .a      (rs_data_a),
        .b      (opnd_a),
        .result (result_a)
    );

    alu u_alu_b (
        .op     (issue_pkt.lane_b.alu_op),
        .a      (rs_data_b),
        .b      (opnd_b),
        .result (result_b)
    );

    assign lane_a_wr = issue_pkt.valid_a && issue_pkt.lane_a.writes &&
                       (issue_pkt.lane_a.dest != '0);
    assign we_b      = issue_pkt.valid_b && issue_pkt.lane_b.writes &&
                       (issue_pkt.lane_b.dest != '0);

    // younger lane wins on a shared destination
    assign we_a = lane_a_wr && !(we_b && (issue_pkt.lane_b.dest == issue_pkt.lane_a.dest));

    assign wb_next.wb_a = '{valid: we_a, dest: issue_pkt.lane_a.dest, data: result_a};
    assign wb_next.wb_b = '{valid: we_b, dest: issue_pkt.lane_b.dest, data: result_b};

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            wb <= '0;
        end
        else
        begin
            wb <= wb_next;
        end
    end

endmodule

// ==== logic/dual_issue_core.sv ====
module dual_issue_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  word_t    inst_a,
    input  word_t    inst_b,
    output pc_t      pc,
    output wb_pair_t wb
);

    packet_t issue_pkt;

    // fetch, decode and pairing
    issue_unit u_issue_unit (
        .clk       (clk),
        .reset     (reset),
        .inst_a    (inst_a),
        .inst_b    (inst_b),
        .pc        (pc),
        .issue_pkt (issue_pkt)
    );

    // register read, both alus and writeback
    execute_unit u_execute_unit (
        .clk       (clk),
        .reset     (reset),
        .issue_pkt (issue_pkt),
        .wb        (wb)
    );

endmodule

// ==== verif/clock_gen.sv ====
module clock_gen (
    output logic clk,
    output logic reset
);

    // 20 unit period and reset low for two rising edges
    initial
    begin
        clk   = 1'b0;
        reset = 1'b0;
        fork
            forever #10 clk = ~clk;
            begin
                repeat (2) @(posedge clk);
                #2 reset = 1'b1;
            end
        join
    end

endmodule

// ==== verif/dual_issue_assertions.sv ====
module dual_issue_assertions
    import pipe_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input wb_pair_t wb
);

    // failed assertions so far
    int fail_count = 0;

    // nothing retires while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !reset |-> (!wb.wb_a.valid && !wb.wb_b.valid))
        else
        begin
            fail_count++;
            $error("wb valid seen during reset");
        end

    // register 0 is never written back
    no_zero_dest_a: assert property (@(posedge clk) disable iff (!reset)
        wb.wb_a.valid |-> (wb.wb_a.dest != '0))
        else
        begin
            fail_count++;
            $error("lane a writeback to register 0");
        end

    no_zero_dest_b: assert property (@(posedge clk) disable iff (!reset)
        wb.wb_b.valid |-> (wb.wb_b.dest != '0))
        else
        begin
            fail_count++;
            $error("lane b writeback to register 0");
        end

    // shared destination must have been resolved to lane b
    distinct_dest: assert property (@(posedge clk) disable iff (!reset)
        !(wb.wb_a.valid && wb.wb_b.valid && (wb.wb_a.dest == wb.wb_b.dest)))
        else
        begin
            fail_count++;
            $error("both lanes write the same register");
        end

endmodule

bind execute_unit dual_issue_assertions u_dual_issue_assertions (
    .clk   (clk),
    .reset (reset),
    .wb    (wb)
);

// ==== verif/tb_dual_issue.sv ====
module tb_dual_issue
    import isa_pkg::*;
    import pipe_pkg::*;
;

    localparam int TABLE_LEN      = 24;
    localparam int FIXED_LEN      = 16;
    localparam int TIMEOUT_CYCLES = TABLE_LEN + 20;

    logic     clk;
    logic     reset;
    word_t    inst_a;
    word_t    inst_b;
    pc_t      pc;
    wb_pair_t wb;

    word_t       prog [TABLE_LEN];
    word_t       shadow [NUM_REGS];
    reg_addr_t   exp_dest [$];
    word_t       exp_data [$];
    int          exp_pc [$];
    int          obs_idx;
    int          pc_idx;
    int          cycles;
    logic [31:0] rng_state;

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    dual_issue_core dut_i (
        .clk    (clk),
        .reset  (reset),
        .inst_a (inst_a),
        .inst_b (inst_b),
        .pc     (pc),
        .wb     (wb)
    );

    function logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs,
                                    input int rt);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t fetch_word(input int addr);
        if (addr < TABLE_LEN)
            return prog[addr];
        return '0;
    endfunction

    // model decode straight from the encoding tables
    function automatic logic word_writes(input word_t w);
        if (w[31:26] == 6'd0)
            return w[5:0] inside {6'd32, 6'd34, 6'd36, 6'd37, 6'd38, 6'd42};
        return w[31:26] inside {6'd8, 6'd10, 6'd12, 6'd13, 6'd14};
    endfunction

    function automatic int word_dest(input word_t w);
        return (w[31:26] == 6'd0) ? int'(w[15:11]) : int'(w[20:16]);
    endfunction

    function automatic word_t model_result(input word_t w);
        word_t x;
        word_t y;
        logic [5:0] sel;
        x = shadow[w[25:21]];
        if (w[31:26] == 6'd0)
        begin
            y   = shadow[w[20:16]];
            sel = w[5:0];
        end
        else
        begin
            sel = w[31:26];
            if (sel == 6'd8 || sel == 6'd10)
                y = {{16{w[15]}}, w[15:0]};
            else
                y = {16'd0, w[15:0]};
        end
        case (sel)
            6'd32, 6'd8:  return x + y;
            6'd34:        return x - y;
            6'd36, 6'd12: return x & y;
            6'd37, 6'd13: return x | y;
            6'd38, 6'd14: return x ^ y;
            default:      return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // walk the program like the core would and record fetches and retired writes
    task automatic build_expected();
        int    addr;
        word_t wa;
        word_t wb_word;
        word_t ra;
        word_t rb;
        int    da;
        int    db;
        logic  wr_a;
        logic  wr_b;
        logic  split;
        for (int i = 0; i < NUM_REGS; i++)
            shadow[i] = '0;
        addr = 0;
        while (addr < TABLE_LEN)
        begin
            exp_pc.push_back(addr);
            wa      = fetch_word(addr);
            wb_word = fetch_word(addr + 1);
            da      = word_dest(wa);
            db      = word_dest(wb_word);
            wr_a    = word_writes(wa) && (da != 0);
            split   = wr_a && ((int'(wb_word[25:21]) == da) ||
                      (wb_word[31:26] == 6'd0 && int'(wb_word[20:16]) == da));
            wr_b    = !split && word_writes(wb_word) && (db != 0);
            ra      = model_result(wa);
            rb      = model_result(wb_word);
            if (wr_a && !(wr_b && db == da))
            begin
                exp_dest.push_back(reg_addr_t'(da));
                exp_data.push_back(ra);
                shadow[da] = ra;
            end
            if (wr_b)
            begin
                exp_dest.push_back(reg_addr_t'(db));
                exp_data.push_back(rb);
                shadow[db] = rb;
            end
            addr += split ? 1 : 2;
        end
    endtask

    task automatic check_value(input string what, input word_t got, input word_t expected);
        if (got !== expected)
        begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic observe_write(input reg_addr_t dest, input word_t data);
        if (obs_idx >= exp_dest.size())
        begin
            $display("Unexpected write to register %0d after all expected writes", dest);
            $display("Errors found");
            $fatal(1);
        end
        else
        begin
            check_value($sformatf("dest of write %0d", obs_idx), word_t'(dest),
                        word_t'(exp_dest[obs_idx]));
            check_value($sformatf("data of write %0d", obs_idx), data, exp_data[obs_idx]);
            obs_idx++;
        end
    endtask

    // fetch words follow pc a little after each edge
    always @(posedge clk)
    begin
        #2;
        inst_a <= fetch_word(int'(pc));
        inst_b <= fetch_word(int'(pc) + 1);
    end

    // wb and pc are stable mid cycle
    always @(negedge clk)
    begin
        if (dut_i.u_execute_unit.u_dual_issue_assertions.fail_count != 0)
        begin
            $display("A writeback assertion failed");
            $display("Errors found");
            $fatal(1);
        end
        else
        begin
            if (reset && pc_idx < exp_pc.size())
            begin
                check_value($sformatf("pc of fetch %0d", pc_idx), word_t'(pc),
                            word_t'(exp_pc[pc_idx]));
                pc_idx++;
            end
            if (wb.wb_a.valid)
                observe_write(wb.wb_a.dest, wb.wb_a.data);
            if (wb.wb_b.valid)
                observe_write(wb.wb_b.dest, wb.wb_b.data);
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("Timeout with %0d of %0d writes seen", obs_idx, exp_dest.size());
            $display("Errors found");
            $fatal(1);
        end
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] r_imm;
        logic [5:0]  functs [6];
        logic [5:0]  opcodes [5];
        inst_a      = '0;
        inst_b      = '0;
        obs_idx     = 0;
        pc_idx      = 0;
        cycles      = 0;
        rng_state   = 32'd14;
        functs  = '{6'd32, 6'd34, 6'd36, 6'd37, 6'd38, 6'd42};
        opcodes = '{6'd8, 6'd10, 6'd12, 6'd13, 6'd14};
        // directed pairs for independent, raw split, shared dest, r0 and immediates
        prog[0]  = enc_i(6'd8, 1, 0, 16'd5);
        prog[1]  = enc_i(6'd8, 2, 0, 16'hfffd);
        prog[2]  = enc_i(6'd8, 3, 1, 16'd7);
        prog[3]  = enc_r(6'd32, 4, 3, 2);
        prog[4]  = enc_i(6'd13, 5, 0, 16'h8001);
        prog[5]  = enc_i(6'd14, 6, 2, 16'hf0f0);
        prog[6]  = enc_i(6'd8, 7, 0, 16'd1);
        prog[7]  = enc_i(6'd8, 7, 1, 16'd2);
        prog[8]  = enc_i(6'd8, 7, 2, 16'd4);
        prog[9]  = enc_r(6'd32, 8, 7, 0);
        prog[10] = enc_i(6'd8, 0, 1, 16'd3);
        prog[11] = enc_r(6'd42, 9, 2, 1);
        prog[12] = enc_i(6'd10, 10, 1, 16'hffff);
        prog[13] = enc_i(6'd12, 11, 2, 16'h8fff);
        prog[14] = enc_r(6'd34, 12, 0, 11);
        prog[15] = enc_r(6'd36, 13, 0, 0);
        // random tail over a small register window
        for (int i = FIXED_LEN; i < TABLE_LEN; i++)
        begin
            r = lcg_next();
            if (r[27:24] < 4'd6)
            begin
                prog[i] = enc_r(functs[r[27:24] % 6], r[18:16], r[21:19], r[24:22]);
            end
            else
            begin
                r_imm   = lcg_next();
                prog[i] = enc_i(opcodes[r[26:24] % 5], r[18:16], r[21:19], r_imm[31:16]);
            end
        end
        build_expected();
        wait (reset === 1'b1);
        wait (obs_idx == exp_dest.size() && pc_idx == exp_pc.size());
        repeat (3) @(negedge clk);
        if (dut_i.u_execute_unit.u_dual_issue_assertions.fail_count == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

// ==== dual_issue_core.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/issue_unit.sv
logic/execute_unit.sv
logic/dual_issue_core.sv
verif/clock_gen.sv
verif/dual_issue_assertions.sv
verif/tb_dual_issue.sv
